//--- src/codecPkg.sv
// arithmetic encoder package with precision and model constants and shared types
package codecPkg;

    localparam int PRECISION = 28;     // code register width
    localparam int NUM_SYMBOLS = 257;
    localparam int WORD_BITS = 32;     // output word width

    typedef logic [$clog2(NUM_SYMBOLS)-1:0] symT;
    typedef logic [PRECISION-1:0] codeT;          // interval bound
    typedef logic [9:0] freqT;                    // cumulative frequency
    typedef logic [PRECISION+9:0] prodT;          // range times frequency
    typedef logic [2:0] byteCountT;               // valid bytes, 1 to 4

    localparam codeT WHOLE = codeT'(1) << (PRECISION - 1);
    localparam codeT HALF = codeT'(1) << (PRECISION - 2);
    localparam codeT QUARTER = codeT'(1) << (PRECISION - 3);
    localparam codeT THREE_QUARTERS = codeT'(3) << (PRECISION - 3);

    localparam symT EOF_SYMBOL = symT'(256);

    // two-region model, cheap low symbols and dearer upper ones
    localparam freqT LOW_REGION_END = freqT'(97);
    localparam freqT HIGH_WEIGHT = freqT'(4);
    localparam freqT EOF_LOW = freqT'(733);
    localparam freqT MODEL_TOTAL = freqT'(734);

    typedef struct packed {
        freqT lower;
        freqT upper;
        logic isEof;
    } boundsT;

    typedef struct packed {
        codeT low;
        codeT high;
    } intervalT;

    typedef struct packed {
        logic [WORD_BITS-1:0] data;
        byteCountT validBytes;
        logic last;
    } outWordT;

endpackage

//--- src/symbolModel.sv
// symbol model stage, buffers one symbol and maps it to cumulative-frequency bounds
module symbolModel (
    input  logic clk,
    input  logic rstn,
    input  logic symValid,
    input  codecPkg::symT sym,
    output logic symReady,
    output logic bndValid,
    output codecPkg::boundsT bnd,
    input  logic bndReady
);

    logic full;                      // buffer holds a symbol
    codecPkg::freqT symFreq;
    codecPkg::boundsT mapped;
    codecPkg::boundsT bndReg;

    assign symReady = !full;
    assign bndValid = full;
    assign bnd = bndReg;

    always_comb begin
        symFreq = codecPkg::freqT'(sym);
        mapped.isEof = (sym == codecPkg::EOF_SYMBOL);
        if (mapped.isEof) begin
            mapped.lower = codecPkg::EOF_LOW;
            mapped.upper = codecPkg::MODEL_TOTAL;
        end else if (symFreq < codecPkg::LOW_REGION_END) begin
            mapped.lower = symFreq;             // frequency 1 each
            mapped.upper = symFreq + 10'd1;
        end else begin
            mapped.lower = codecPkg::LOW_REGION_END
                + codecPkg::HIGH_WEIGHT * (symFreq - codecPkg::LOW_REGION_END);
            mapped.upper = mapped.lower + codecPkg::HIGH_WEIGHT;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            full <= 1'b0;
        end else if (symValid && symReady) begin
            full <= 1'b1;
        end else if (bndValid && bndReady) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (symValid && symReady) begin
            bndReg <= mapped;
        end
    end

endmodule

//--- src/intervalUpdate.sv
// interval update stage that scales the range by the symbol bounds with a serial restoring divider
module intervalUpdate (
    input  logic clk,
    input  logic rstn,
    input  logic bndValid,
    input  codecPkg::boundsT bnd,
    output logic bndReady,
    input  logic stageFree,
    input  codecPkg::intervalT cur,
    output codecPkg::intervalT nxt,
    output logic isEof,
    output logic updDone
);

    typedef enum logic [2:0] {
        IDLE,
        MULT,
        DIV_HIGH,
        DIV_LOW,
        DONE
    } stateT;

    stateT state;
    logic [5:0] stepCnt;             // divider step counter over the product bits
    logic lastStep;
    codecPkg::boundsT bndReg;
    codecPkg::codeT range;
    codecPkg::prodT quot;            // dividend out at the top and quotient in at the bottom
    codecPkg::prodT prodLow;         // waits for the second division
    codecPkg::freqT rem;
    logic [10:0] shifted;
    logic [11:0] diff;
    logic fits;
    codecPkg::freqT remNext;
    codecPkg::prodT quotNext;
    codecPkg::codeT bound;

    assign range = cur.high - cur.low;
    assign bndReady = (state == IDLE) && stageFree;
    assign updDone = (state == DONE);
    assign isEof = bndReg.isEof;
    assign lastStep = (stepCnt == 6'(codecPkg::PRECISION + 9));

    // one restoring step against the model total
    always_comb begin
        shifted = {rem, quot[$bits(codecPkg::prodT)-1]};
        diff = {1'b0, shifted} - {2'b00, codecPkg::MODEL_TOTAL};
        fits = !diff[11];
        remNext = fits ? diff[9:0] : shifted[9:0];
        quotNext = {quot[$bits(codecPkg::prodT)-2:0], fits};
        bound = cur.low + codecPkg::codeT'(quotNext);   // quotient never exceeds range
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
            stepCnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (bndValid && bndReady) begin
                        state <= MULT;
                    end
                end
                MULT: begin
                    stepCnt <= '0;
                    state <= DIV_HIGH;
                end
                DIV_HIGH: begin
                    if (lastStep) begin
                        stepCnt <= '0;
                        state <= DIV_LOW;
                    end else begin
                        stepCnt <= stepCnt + 6'd1;
                    end
                end
                DIV_LOW: begin
                    if (lastStep) begin
                        state <= DONE;
                    end else begin
                        stepCnt <= stepCnt + 6'd1;
                    end
                end
                default: begin
                    state <= IDLE;                 // updDone lasts one cycle
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            IDLE: begin
                if (bndValid && bndReady) begin
                    bndReg <= bnd;
                end
            end
            MULT: begin
                quot <= codecPkg::prodT'(range) * codecPkg::prodT'(bndReg.upper);
                prodLow <= codecPkg::prodT'(range) * codecPkg::prodT'(bndReg.lower);
                rem <= '0;
            end
            DIV_HIGH: begin
                if (lastStep) begin
                    nxt.high <= bound;
                    quot <= prodLow;               // start the low bound division
                    rem <= '0;
                end else begin
                    quot <= quotNext;
                    rem <= remNext;
                end
            end
            DIV_LOW: begin
                quot <= quotNext;
                rem <= remNext;
                if (lastStep) begin
                    nxt.low <= bound;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

//--- src/renormalizer.sv
// renormalizer stage, holds the interval, rescales it, emits bits and flushes at end of message
module renormalizer (
    input  logic clk,
    input  logic rstn,
    input  logic updDone,
    input  codecPkg::intervalT nxt,
    input  logic isEof,
    output codecPkg::intervalT cur,
    output logic stageFree,
    output logic bitValid,
    output logic bitVal,
    output logic bitLast,
    input  logic bitReady
);

    typedef enum logic [1:0] {
        IDLE,
        SCALE,
        EMIT
    } stateT;

    stateT state;
    codecPkg::intervalT iv;
    logic eofSeen;                   // symbol in flight ended the message
    logic flushing;                  // emitting the final bits
    logic [7:0] pending;             // bits held back by the middle case
    logic curBit;
    logic fillBit;                   // value of the pending bits, opposite to the leading one

    assign cur = iv;
    assign stageFree = (state == IDLE);
    assign bitValid = (state == EMIT);
    assign bitVal = curBit;
    assign bitLast = flushing && (pending == 8'd0);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
            iv.low <= '0;
            iv.high <= codecPkg::WHOLE;
            eofSeen <= 1'b0;
            flushing <= 1'b0;
            pending <= '0;
            curBit <= 1'b0;
            fillBit <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (updDone) begin
                        iv <= nxt;
                        eofSeen <= isEof;
                        state <= SCALE;
                    end
                end
                SCALE: begin
                    if (iv.high < codecPkg::HALF) begin
                        curBit <= 1'b0;                // lower half
                        fillBit <= 1'b1;
                        iv.low <= iv.low << 1;
                        iv.high <= iv.high << 1;
                        state <= EMIT;
                    end else if (iv.low > codecPkg::HALF) begin
                        curBit <= 1'b1;                // upper half
                        fillBit <= 1'b0;
                        iv.low <= (iv.low - codecPkg::HALF) << 1;
                        iv.high <= (iv.high - codecPkg::HALF) << 1;
                        state <= EMIT;
                    end else if (iv.low > codecPkg::QUARTER
                                 && iv.high < codecPkg::THREE_QUARTERS) begin
                        pending <= pending + 8'd1;     // middle case, decide later
                        iv.low <= (iv.low - codecPkg::QUARTER) << 1;
                        iv.high <= (iv.high - codecPkg::QUARTER) << 1;
                    end else if (eofSeen) begin
                        // one extra pending bit picks the quarter inside the interval
                        pending <= pending + 8'd1;
                        flushing <= 1'b1;
                        curBit <= (iv.low > codecPkg::QUARTER);
                        fillBit <= !(iv.low > codecPkg::QUARTER);
                        state <= EMIT;
                    end else begin
                        state <= IDLE;
                    end
                end
                default: begin
                    if (bitReady) begin
                        if (pending != 8'd0) begin
                            curBit <= fillBit;
                            pending <= pending - 8'd1;
                        end else if (flushing) begin
                            flushing <= 1'b0;          // message done, back to initial interval
                            eofSeen <= 1'b0;
                            iv.low <= '0;
                            iv.high <= codecPkg::WHOLE;
                            state <= IDLE;
                        end else begin
                            state <= SCALE;
                        end
                    end
                end
            endcase
        end
    end

endmodule

//--- src/wordPacker.sv
// word packer, collects emitted bits LSB first into 32-bit words with byte count and last flag
module wordPacker (
    input  logic clk,
    input  logic rstn,
    input  logic bitValid,
    input  logic bitVal,
    input  logic bitLast,
    output logic bitReady,
    output logic outValid,
    output codecPkg::outWordT outWord,
    input  logic outReady
);

    codecPkg::outWordT wordReg;
    logic [$clog2(codecPkg::WORD_BITS)-1:0] bitPos;    // next free bit
    logic wordValid;
    logic bitTake;
    logic wordDone;
    codecPkg::byteCountT bytesUsed;

    assign bitReady = !wordValid;    // stall bits while the word waits
    assign outValid = wordValid;
    assign outWord = wordReg;
    assign bitTake = bitValid && bitReady;
    assign wordDone = bitLast || (bitPos == codecPkg::WORD_BITS - 1);
    assign bytesUsed = codecPkg::byteCountT'(({1'b0, bitPos} + 6'd8) >> 3);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wordValid <= 1'b0;
            bitPos <= '0;
            wordReg <= '0;
        end else if (wordValid) begin
            if (outReady) begin
                wordValid <= 1'b0;
                wordReg <= '0;                 // unused bits of the next word read zero
            end
        end else if (bitTake) begin
            wordReg.data[bitPos] <= bitVal;
            if (wordDone) begin
                wordValid <= 1'b1;
                wordReg.validBytes <= bytesUsed;
                wordReg.last <= bitLast;
                bitPos <= '0;
            end else begin
                bitPos <= bitPos + 1'b1;
            end
        end
    end

endmodule

//--- src/arithEncoder.sv
// arithmetic encoder top, chains symbol model, interval update, renormalizer and word packer
module arithEncoder (
    input  logic clk,
    input  logic rstn,
    input  logic symValid,
    input  codecPkg::symT sym,
    output logic symReady,
    output logic outValid,
    output codecPkg::outWordT outWord,
    input  logic outReady
);

    logic bndValid;
    logic bndReady;
    codecPkg::boundsT bnd;

    codecPkg::intervalT cur;         // interval held by the renormalizer
    codecPkg::intervalT nxt;         // narrowed interval
    logic isEof;
    logic updDone;
    logic stageFree;

    logic bitValid;
    logic bitVal;
    logic bitLast;
    logic bitReady;

    symbolModel model_i (
        .clk      (clk),
        .rstn     (rstn),
        .symValid (symValid),
        .sym      (sym),
        .symReady (symReady),
        .bndValid (bndValid),
        .bnd      (bnd),
        .bndReady (bndReady)
    );

    intervalUpdate update_i (
        .clk       (clk),
        .rstn      (rstn),
        .bndValid  (bndValid),
        .bnd       (bnd),
        .bndReady  (bndReady),
        .stageFree (stageFree),
        .cur       (cur),
        .nxt       (nxt),
        .isEof     (isEof),
        .updDone   (updDone)
    );

    renormalizer renorm_i (
        .clk       (clk),
        .rstn      (rstn),
        .updDone   (updDone),
        .nxt       (nxt),
        .isEof     (isEof),
        .cur       (cur),
        .stageFree (stageFree),
        .bitValid  (bitValid),
        .bitVal    (bitVal),
        .bitLast   (bitLast),
        .bitReady  (bitReady)
    );

    wordPacker packer_i (
        .clk      (clk),
        .rstn     (rstn),
        .bitValid (bitValid),
        .bitVal   (bitVal),
        .bitLast  (bitLast),
        .bitReady (bitReady),
        .outValid (outValid),
        .outWord  (outWord),
        .outReady (outReady)
    );

endmodule

//--- test/arithEncoderTb.sv
// arithmetic encoder testbench that replays the cases file and checks every output word
module arithEncoderTb;

    localparam int CASE_DEPTH = 256;
    localparam int WAIT_LIMIT = 5000;            // cycles allowed for any single wait
    localparam logic [31:0] SEED = 32'hef63_8a82;

    logic clk;
    logic rstn;
    logic symValid;
    codecPkg::symT sym;
    logic symReady;
    logic outValid;
    codecPkg::outWordT outWord;
    logic outReady;

    logic [35:0] caseMem [0:CASE_DEPTH-1];       // counts, symbols and packed expected words
    codecPkg::symT symList[$];
    codecPkg::outWordT expList[$];
    int valueErrors;
    int timeoutErrors;

    arithEncoder dut_i (
        .clk      (clk),
        .rstn     (rstn),
        .symValid (symValid),
        .sym      (sym),
        .symReady (symReady),
        .outValid (outValid),
        .outWord  (outWord),
        .outReady (outReady)
    );

    always #2 clk = ~clk;

    // flatten all cases into one symbol stream and one expected word stream
    task automatic loadCases();
        int idx;
        int count;
        idx = 0;
        $readmemh("test/encoderCases.txt", caseMem);
        while (idx < CASE_DEPTH && caseMem[idx] != 36'd0) begin
            count = int'(caseMem[idx]);
            idx++;
            for (int i = 0; i < count; i++) begin
                symList.push_back(codecPkg::symT'(caseMem[idx]));
                idx++;
            end
            count = int'(caseMem[idx]);
            idx++;
            for (int i = 0; i < count; i++) begin
                expList.push_back(codecPkg::outWordT'(caseMem[idx]));
                idx++;
            end
        end
    endtask

    task automatic checkWord(input codecPkg::outWordT got, input codecPkg::outWordT exp,
                             input int idx);
        assert (got.data == exp.data) else begin
            $display("CHECK FAILED outWord.data word %0d: got %h expected %h",
                     idx, got.data, exp.data);
            valueErrors++;
        end
        assert (got.validBytes == exp.validBytes) else begin
            $display("CHECK FAILED outWord.validBytes word %0d: got %h expected %h",
                     idx, got.validBytes, exp.validBytes);
            valueErrors++;
        end
        assert (got.last == exp.last) else begin
            $display("CHECK FAILED outWord.last word %0d: got %h expected %h",
                     idx, got.last, exp.last);
            valueErrors++;
        end
    endtask

    // entered and left right after a rising edge
    task automatic sendSymbols(input bit randomGaps);
        int gap;
        int waited;
        bit accepted;
        bit timedOut;
        timedOut = 1'b0;
        foreach (symList[i]) begin
            if (timedOut) begin
                break;
            end
            if (randomGaps) begin
                gap = int'($urandom % 4);
                symValid <= 1'b0;
                repeat (gap) @(posedge clk);
            end
            symValid <= 1'b1;
            sym <= symList[i];
            waited = 0;
            accepted = 1'b0;
            while (!accepted && !timedOut) begin
                @(negedge clk);
                accepted = symReady;                // transfer on the coming edge
                @(posedge clk);
                waited++;
                if (!accepted && waited > WAIT_LIMIT) begin
                    $display("timeout: symbol %0d was not accepted in time", i);
                    timeoutErrors++;
                    timedOut = 1'b1;
                end
            end
        end
        symValid <= 1'b0;
    endtask

    task automatic receiveWords(input bit randomReady);
        int waited;
        bit got;
        bit holding;
        bit timedOut;
        codecPkg::outWordT heldWord;
        timedOut = 1'b0;
        holding = 1'b0;
        heldWord = '0;
        foreach (expList[i]) begin
            if (timedOut) begin
                break;
            end
            waited = 0;
            got = 1'b0;
            while (!got && !timedOut) begin
                @(negedge clk);
                if (holding) begin
                    assert (outValid) else begin
                        $display("CHECK FAILED outValid while stalled: got %h expected %h",
                                 outValid, 1'b1);
                        valueErrors++;
                        holding = 1'b0;
                    end
                end
                if (outValid) begin
                    if (holding) begin
                        assert (outWord == heldWord) else begin
                            $display("CHECK FAILED outWord changed while stalled: got %h expected %h",
                                     outWord, heldWord);
                            valueErrors++;
                        end
                    end
                    if (outReady) begin
                        checkWord(outWord, expList[i], i);
                        got = 1'b1;
                        holding = 1'b0;
                    end else begin
                        holding = 1'b1;
                        heldWord = outWord;
                    end
                end
                @(posedge clk);
                outReady <= randomReady ? (($urandom % 3) != 0) : 1'b1;
                waited++;
                if (!got && waited > WAIT_LIMIT) begin
                    $display("timeout: output word %0d never arrived", i);
                    timeoutErrors++;
                    timedOut = 1'b1;
                end
            end
        end
        outReady <= 1'b1;
    endtask

    task automatic runPass(input bit randomMode);
        fork
            sendSymbols(randomMode);
            receiveWords(randomMode);
        join
        repeat (100) @(posedge clk);
        @(negedge clk);
        assert (!outValid) else begin
            $display("an extra output word appeared after the last expected one");
            valueErrors++;
        end
        @(posedge clk);
    endtask

    initial begin
        void'($urandom(SEED));
        clk = 1'b0;
        rstn = 1'b0;
        symValid = 1'b0;
        sym = '0;
        outReady = 1'b0;
        valueErrors = 0;
        timeoutErrors = 0;
        loadCases();
        repeat (5) @(posedge clk);
        rstn <= 1'b1;
        outReady <= 1'b1;
        @(negedge clk);
        assert (symReady) else begin
            $display("CHECK FAILED symReady after reset: got %h expected %h", symReady, 1'b1);
            valueErrors++;
        end
        assert (!outValid) else begin
            $display("CHECK FAILED outValid after reset: got %h expected %h", outValid, 1'b0);
            valueErrors++;
        end
        @(posedge clk);
        runPass(1'b0);                           // steady stream without back-pressure
        runPass(1'b1);                           // input gaps and random outReady
        $display("errors: %0d value, %0d timeout", valueErrors, timeoutErrors);
        if (valueErrors == 0 && timeoutErrors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- test/encoderCases.txt
// per case: symbol count, symbols, word count, then each word as {data, validBytes, last}
// hex values, a symbol count of zero ends the list

// end-of-message alone, flush of the initial interval
1
100
1
000003ff5

// one cheap symbol, one dear symbol, end of message
3
0 ff 100
1
07949a009

// four cheap symbols span two words
5
0 0 0 0 100
2
000000008
000113c07

0

//--- list.f
src/codecPkg.sv
src/symbolModel.sv
src/intervalUpdate.sv
src/renormalizer.sv
src/wordPacker.sv
src/arithEncoder.sv
test/arithEncoderTb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module arithEncoderTb -o simv \
    && ./obj_dir/simv | tee /dev/stderr | grep -q "All checks passed" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
